// ==== design/erx_pkg.sv ====
// Types and constants shared by the receive path RTL and testbench, used by scoped name
`default_nettype none

package erx_pkg;

   // Field widths
   localparam int ADDR_W      = 32;            // Mesh address
   localparam int DATA_W      = 32;            // Payload word
   localparam int DATAMODE_W  = 2;             // Access size code
   localparam int CTRLMODE_W  = 4;             // Control mode
   localparam int PAGE_W      = 12;            // Page number width
   localparam int PAGE_LSB    = 20;            // Page sits in dstaddr[31:20]
   localparam int MMU_IDX_W   = 4;             // Table index width
   localparam int MMU_IDX_LSB = 28;            // Index taken from dstaddr[31:28]
   localparam int BEAT_W      = 64;            // Parallel link beat
   localparam int FRAME_W     = 8;             // Frame bits per beat

   // Header beat layout, byte 7 carries the control fields
   localparam int HDR_WRITE_BIT    = 56;       // Byte 7 bit 0
   localparam int HDR_DATAMODE_LSB = 57;       // Byte 7 bits 2:1
   localparam int HDR_CTRLMODE_LSB = 59;       // Byte 7 bits 6:3
   localparam int HDR_DSTADDR_LSB  = 0;        // Bytes 3..0

   // Body beat layout
   localparam int BODY_DATA_LSB    = 32;       // Upper word
   localparam int BODY_SRCADDR_LSB = 0;        // Lower word

   // Page table
   localparam int MMU_ENTRIES = 16;            // One entry per index value

   // Queues
   localparam int QUEUE_DEPTH      = 16;       // Packets per queue
   localparam int QUEUE_PTR_W      = $clog2(QUEUE_DEPTH);
   localparam int QUEUE_CNT_W      = QUEUE_PTR_W + 1; // Holds 0..DEPTH
   localparam int QUEUE_PROG_LEVEL = 8;        // Almost-full threshold

   // Vector types with a meaning of their own
   typedef logic [ADDR_W-1:0]      erx_addr_t;
   typedef logic [DATA_W-1:0]      erx_data_t;
   typedef logic [DATAMODE_W-1:0]  erx_datamode_t;
   typedef logic [CTRLMODE_W-1:0]  erx_ctrlmode_t;
   typedef logic [PAGE_W-1:0]      erx_page_t;
   typedef logic [MMU_IDX_W-1:0]   erx_mmu_idx_t;
   typedef logic [BEAT_W-1:0]      erx_beat_t;
   typedef logic [FRAME_W-1:0]     erx_frame_t;
   typedef logic [QUEUE_PTR_W-1:0] erx_qptr_t;
   typedef logic [QUEUE_CNT_W-1:0] erx_qcnt_t;

   // Read responses land in this page after translation
   localparam erx_page_t RESP_PAGE = 12'h810;

   // Mesh packet, 103 bits, write is the MSB
   typedef struct packed {
      logic          write;                    // 1 = write, 0 = read request
      erx_datamode_t datamode;                 // Access size
      erx_ctrlmode_t ctrlmode;                 // Control mode
      erx_addr_t     dstaddr;                  // Destination
      erx_addr_t     srcaddr;                  // Return address for reads
      erx_data_t     data;                     // Write payload
   } erx_packet_t;

endpackage

`default_nettype wire

// ==== design/erx_protocol.sv ====
// Frame decoder, pairs link header and body beats into mesh packets with a valid strobe
`default_nettype none

module erx_protocol
(
   input  wire                 rx_lclk_div4,   // Divided link clock
   input  wire                 rst_n,          // Sync reset, active low
   input  wire                 rx_enable,      // Receiver enable
   input  erx_pkg::erx_frame_t rx_frame_par,   // Frame bits, one per byte
   input  erx_pkg::erx_beat_t  rx_data_par,    // Parallel beat
   output erx_pkg::erx_packet_t pkt,           // Assembled packet
   output logic                pkt_valid       // One cycle per packet
);

   // Beat parity inside a run of frame beats
   typedef enum logic
   {
      ST_HDR,                                  // Next beat is a header
      ST_BODY                                  // Next beat is a body
   } state_t;

   state_t state;
   logic   in_frame;                           // Beat belongs to a frame
   logic   take_hdr;                           // Capture header fields
   logic   take_body;                          // Complete packet

   // Header fields held between the two beats
   logic                   hdr_write;
   erx_pkg::erx_datamode_t hdr_datamode;
   erx_pkg::erx_ctrlmode_t hdr_ctrlmode;
   erx_pkg::erx_addr_t     hdr_dstaddr;

   // Frame bits are all ones inside a frame, all zeros between
   assign in_frame  = rx_enable && (rx_frame_par == '1);
   assign take_hdr  = in_frame && (state == ST_HDR);
   assign take_body = in_frame && (state == ST_BODY);

   // Parity tracking
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         state <= ST_HDR;                      // Expect a header first
      end
      else if (!in_frame)
      begin
         state <= ST_HDR;                      // Idle or disabled resyncs
      end
      else if (state == ST_HDR)
      begin
         state <= ST_BODY;
      end
      else
      begin
         state <= ST_HDR;                      // Back-to-back frames continue here
      end
   end

   // Header capture, byte 7 control bits and low word address
   always_ff @(posedge rx_lclk_div4)
   begin
      if (take_hdr)
      begin
         hdr_write    <= rx_data_par[erx_pkg::HDR_WRITE_BIT];
         hdr_datamode <= rx_data_par[erx_pkg::HDR_DATAMODE_LSB +: erx_pkg::DATAMODE_W];
         hdr_ctrlmode <= rx_data_par[erx_pkg::HDR_CTRLMODE_LSB +: erx_pkg::CTRLMODE_W];
         hdr_dstaddr  <= rx_data_par[erx_pkg::HDR_DSTADDR_LSB +: erx_pkg::ADDR_W];
      end
   end

   // Packet register, loaded with the body beat
   always_ff @(posedge rx_lclk_div4)
   begin
      if (take_body)
      begin
         pkt.write    <= hdr_write;
         pkt.datamode <= hdr_datamode;
         pkt.ctrlmode <= hdr_ctrlmode;
         pkt.dstaddr  <= hdr_dstaddr;
         pkt.data     <= rx_data_par[erx_pkg::BODY_DATA_LSB +: erx_pkg::DATA_W];
         pkt.srcaddr  <= rx_data_par[erx_pkg::BODY_SRCADDR_LSB +: erx_pkg::ADDR_W];
      end
   end

   // Strobe for the cycle after the body beat
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         pkt_valid <= 1'b0;
      end
      else
      begin
         pkt_valid <= take_body;
      end
   end

endmodule

`default_nettype wire

// ==== design/erx_mmu.sv ====
// Destination address translator with a programmable page table and register read-back
`default_nettype none

module erx_mmu
(
   input  wire                   rx_lclk_div4,  // Divided link clock
   input  wire                   rst_n,         // Sync reset, active low
   input  wire                   mmu_en,        // Translate when high
   input  wire                   mi_en,         // Table access
   input  wire                   mi_we,         // Write when set with mi_en
   input  erx_pkg::erx_mmu_idx_t mi_addr,       // Table entry
   input  erx_pkg::erx_page_t    mi_din,        // New page value
   input  erx_pkg::erx_packet_t  pkt,           // From decoder
   input  wire                   pkt_valid,
   output erx_pkg::erx_page_t    mi_dout,       // Read-back, one cycle later
   output erx_pkg::erx_packet_t  xpkt,          // Translated packet
   output logic                  xpkt_valid
);

   erx_pkg::erx_page_t    page_table [erx_pkg::MMU_ENTRIES];  // Page per index
   erx_pkg::erx_mmu_idx_t lookup_idx;           // Top nibble of dstaddr
   erx_pkg::erx_page_t    lookup_page;          // Entry for this packet
   erx_pkg::erx_packet_t  xlat_pkt;             // Packet after translation

   assign lookup_idx  = pkt.dstaddr[erx_pkg::MMU_IDX_LSB +: erx_pkg::MMU_IDX_W];
   assign lookup_page = page_table[lookup_idx];

   // Replace upper 12 address bits, keep the low 20
   always_comb
   begin
      xlat_pkt = pkt;
      if (mmu_en)
      begin
         xlat_pkt.dstaddr[erx_pkg::PAGE_LSB +: erx_pkg::PAGE_W] = lookup_page;
      end
   end

   // Table writes, cleared so a fresh table maps everything to page 0
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < erx_pkg::MMU_ENTRIES; i++)
         begin
            page_table[i] <= '0;
         end
      end
      else if (mi_en && mi_we)
      begin
         page_table[mi_addr] <= mi_din;
      end
   end

   // Register read port
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         mi_dout <= '0;
      end
      else if (mi_en && !mi_we)
      begin
         mi_dout <= page_table[mi_addr];          // Held until next read
      end
   end

   // Pipeline stage towards the distributor
   always_ff @(posedge rx_lclk_div4)
   begin
      xpkt <= xlat_pkt;                           // Payload, qualified by valid
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         xpkt_valid <= 1'b0;
      end
      else
      begin
         xpkt_valid <= pkt_valid;
      end
   end

endmodule

`default_nettype wire

// ==== design/erx_disty.sv ====
// Distributor, steers each packet to the write, request or response queue and drives link waits
`default_nettype none

module erx_disty
(
   input  wire                  rx_lclk_div4,  // Divided link clock
   input  wire                  rst_n,         // Sync reset, active low
   input  erx_pkg::erx_packet_t xpkt,          // From translator
   input  wire                  xpkt_valid,
   input  wire                  wr_ready,      // Write queue not full
   input  wire                  rq_ready,      // Request queue not full
   input  wire                  rr_ready,      // Response queue not full
   input  wire                  wr_prog_full,  // Write queue almost full
   input  wire                  rq_prog_full,  // Request queue almost full
   input  wire                  rr_prog_full,  // Response queue almost full
   output erx_pkg::erx_packet_t q_pkt,         // Shared bus to all queues
   output logic                 wr_valid,
   output logic                 rq_valid,
   output logic                 rr_valid,
   output logic                 rx_wr_wait,    // Pushback on writes
   output logic                 rx_rd_wait     // Pushback on reads
);

   logic to_wr;                                // Plain write
   logic to_rq;                                // Read request
   logic to_rr;                                // Read response
   logic resp_page;                            // Translated page hits response page

   assign resp_page = (xpkt.dstaddr[erx_pkg::PAGE_LSB +: erx_pkg::PAGE_W] ==
                       erx_pkg::RESP_PAGE);
   assign to_rq     = !xpkt.write;
   assign to_rr     = xpkt.write && resp_page;
   assign to_wr     = xpkt.write && !resp_page;

   // One bus, the valids pick the target
   always_ff @(posedge rx_lclk_div4)
   begin
      q_pkt <= xpkt;
   end

   // At most one valid per packet, dropped if target is full
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         wr_valid <= 1'b0;
         rq_valid <= 1'b0;
         rr_valid <= 1'b0;
      end
      else
      begin
         wr_valid <= xpkt_valid && to_wr && wr_ready;
         rq_valid <= xpkt_valid && to_rq && rq_ready;
         rr_valid <= xpkt_valid && to_rr && rr_ready;
      end
   end

   // Responses count as write traffic on the link
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         rx_wr_wait <= 1'b0;
         rx_rd_wait <= 1'b0;
      end
      else
      begin
         rx_wr_wait <= wr_prog_full || rr_prog_full;
         rx_rd_wait <= rq_prog_full;
      end
   end

endmodule

`default_nettype wire

// ==== design/erx_queue.sv ====
// Synchronous show-ahead packet queue with valid/ready on both ends and an almost-full flag
`default_nettype none

module erx_queue
(
   input  wire                  rx_lclk_div4,  // Divided link clock
   input  wire                  rst_n,         // Sync reset, active low
   input  erx_pkg::erx_packet_t in_pkt,        // Packet to store
   input  wire                  in_valid,
   output logic                 in_ready,      // Room for one more
   output logic                 prog_full,     // At or above threshold
   output erx_pkg::erx_packet_t out_pkt,       // Oldest packet
   output logic                 out_valid,
   input  wire                  out_ready      // Consumer takes out_pkt
);

   erx_pkg::erx_packet_t mem [erx_pkg::QUEUE_DEPTH]; // Packet storage
   erx_pkg::erx_qptr_t   wr_ptr;               // Next free slot
   erx_pkg::erx_qptr_t   rd_ptr;               // Oldest entry
   erx_pkg::erx_qcnt_t   count;                // Entries held
   logic                 push;
   logic                 pop;

   assign in_ready  = (count != erx_pkg::erx_qcnt_t'(erx_pkg::QUEUE_DEPTH));
   assign prog_full = (count >= erx_pkg::erx_qcnt_t'(erx_pkg::QUEUE_PROG_LEVEL));
   assign out_valid = (count != '0);
   assign out_pkt   = mem[rd_ptr];             // Show-ahead read
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   // Storage write
   always_ff @(posedge rx_lclk_div4)
   begin
      if (push)
      begin
         mem[wr_ptr] <= in_pkt;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge rx_lclk_div4)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;   // Push with pop leaves count alone
      end
   end

endmodule

`default_nettype wire

// ==== design/erx_core.sv ====
// Receive path top level, decoder through translator and distributor into three packet queues
`default_nettype none

module erx_core
(
   input  wire                   rx_lclk_div4,  // Divided link clock
   input  wire                   rst_n,         // Sync reset, active low
   input  wire                   rx_enable,     // Receiver enable
   input  wire                   mmu_en,        // Address translation on
   input  erx_pkg::erx_frame_t   rx_frame_par,  // Link frame bits
   input  erx_pkg::erx_beat_t    rx_data_par,   // Link data beat
   input  wire                   mi_en,         // Page table access
   input  wire                   mi_we,
   input  erx_pkg::erx_mmu_idx_t mi_addr,
   input  erx_pkg::erx_page_t    mi_din,
   output erx_pkg::erx_page_t    mi_dout,
   output erx_pkg::erx_packet_t  wr_pkt,        // Write queue output
   output logic                  wr_valid,
   input  wire                   wr_ready,
   output erx_pkg::erx_packet_t  rq_pkt,        // Read request queue output
   output logic                  rq_valid,
   input  wire                   rq_ready,
   output erx_pkg::erx_packet_t  rr_pkt,        // Read response queue output
   output logic                  rr_valid,
   input  wire                   rr_ready,
   output logic                  rx_wr_wait,    // To link partner
   output logic                  rx_rd_wait
);

   erx_pkg::erx_packet_t pkt, xpkt, q_pkt;     // Pipeline stages
   logic pkt_valid, xpkt_valid;
   logic wr_in_valid, rq_in_valid, rr_in_valid;  // Distributor to queues
   logic wr_in_ready, rq_in_ready, rr_in_ready;
   logic wr_prog_full, rq_prog_full, rr_prog_full;

   erx_protocol erx_protocol_i (.rx_lclk_div4, .rst_n, .rx_enable, .rx_frame_par,
                                .rx_data_par, .pkt, .pkt_valid);

   erx_mmu erx_mmu_i (.rx_lclk_div4, .rst_n, .mmu_en, .mi_en, .mi_we, .mi_addr, .mi_din,
                      .pkt, .pkt_valid, .mi_dout, .xpkt, .xpkt_valid);

   erx_disty erx_disty_i (.rx_lclk_div4, .rst_n, .xpkt, .xpkt_valid,
                          .wr_ready(wr_in_ready), .rq_ready(rq_in_ready),
                          .rr_ready(rr_in_ready), .wr_prog_full, .rq_prog_full,
                          .rr_prog_full, .q_pkt, .wr_valid(wr_in_valid),
                          .rq_valid(rq_in_valid), .rr_valid(rr_in_valid),
                          .rx_wr_wait, .rx_rd_wait);

   // Plain writes
   erx_queue wr_queue (.rx_lclk_div4, .rst_n, .in_pkt(q_pkt), .in_valid(wr_in_valid),
                       .in_ready(wr_in_ready), .prog_full(wr_prog_full),
                       .out_pkt(wr_pkt), .out_valid(wr_valid), .out_ready(wr_ready));

   // Read requests
   erx_queue rq_queue (.rx_lclk_div4, .rst_n, .in_pkt(q_pkt), .in_valid(rq_in_valid),
                       .in_ready(rq_in_ready), .prog_full(rq_prog_full),
                       .out_pkt(rq_pkt), .out_valid(rq_valid), .out_ready(rq_ready));

   // Read responses
   erx_queue rr_queue (.rx_lclk_div4, .rst_n, .in_pkt(q_pkt), .in_valid(rr_in_valid),
                       .in_ready(rr_in_ready), .prog_full(rr_prog_full),
                       .out_pkt(rr_pkt), .out_valid(rr_valid), .out_ready(rr_ready));

endmodule

`default_nettype wire

// ==== sim/erx_tb.sv ====
// Self-checking testbench for the receive path, compiled from src.f with erx_tb as top
`default_nettype none

module erx_tb;

   localparam int ROUTE_PKTS = 24;             // Per pass-through half
   localparam int XLAT_PKTS  = 32;
   localparam int PRESS_PKTS = 14;             // Per back-pressure run
   localparam int QUIET_PKTS = 8;              // Per disabled half
   localparam int TIMEOUT_CYCLES =
      40 * (2 * ROUTE_PKTS + XLAT_PKTS + 2 * PRESS_PKTS + 2 * QUIET_PKTS) + 500;
   localparam logic [1:0] READY_ON   = 2'd0;
   localparam logic [1:0] READY_OFF  = 2'd1;
   localparam logic [1:0] READY_RAND = 2'd2;

   logic                  rx_lclk_div4;
   logic                  rst_n;
   logic                  rx_enable;
   logic                  mmu_en;
   erx_pkg::erx_frame_t   rx_frame_par;
   erx_pkg::erx_beat_t    rx_data_par;
   logic                  mi_en, mi_we;
   erx_pkg::erx_mmu_idx_t mi_addr;
   erx_pkg::erx_page_t    mi_din, mi_dout;
   erx_pkg::erx_packet_t  wr_pkt, rq_pkt, rr_pkt;
   logic                  wr_valid, rq_valid, rr_valid;
   logic                  wr_ready, rq_ready, rr_ready;
   logic                  rx_wr_wait, rx_rd_wait;

   erx_pkg::erx_packet_t  wr_exp[$], rq_exp[$], rr_exp[$];   // Scoreboards, arrival order
   erx_pkg::erx_page_t    page_model [erx_pkg::MMU_ENTRIES]; // Expected table contents
   logic [1:0]            wr_mode, rq_mode, rr_mode;          // Consumer behavior
   logic [31:0]           coin;                // Random ready bits
   integer                seed;
   string                 test_name;
   int                    cycles;
   int                    i;
   logic                  rst_q;               // rst_n one edge ago
   logic                  rd_pend;             // Table read issued last edge
   erx_pkg::erx_mmu_idx_t rd_idx;
   logic                  quiet_chk;           // Receiver disabled window

   erx_core erx_core_i (.rx_lclk_div4, .rst_n, .rx_enable, .mmu_en, .rx_frame_par,
                        .rx_data_par, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
                        .wr_pkt, .wr_valid, .wr_ready, .rq_pkt, .rq_valid, .rq_ready,
                        .rr_pkt, .rr_valid, .rr_ready, .rx_wr_wait, .rx_rd_wait);

   always #5 rx_lclk_div4 = ~rx_lclk_div4;

   task automatic fail_run(input string why);
      $display("ERROR %s: %s", test_name, why);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input string exp_s, input string act_s);
      fail_run($sformatf("%s expected %s actual %s", what, exp_s, act_s));
   endtask

   task automatic next_cycle();
      @(posedge rx_lclk_div4);
      #1;                                      // Drive point after the edge
   endtask

   task automatic link_idle();
      rx_frame_par = '0;
      rx_data_par  = {$random(seed), $random(seed)};   // Junk between frames
   endtask

   function automatic erx_pkg::erx_packet_t random_packet(input int kind);
      erx_pkg::erx_packet_t p;
      logic [31:0]          r;
      r          = $random(seed);
      p.write    = (kind != 0);                // 0 read, 1 response, 2 plain write
      p.datamode = r[1:0];
      p.ctrlmode = r[5:2];
      p.dstaddr  = $random(seed);
      p.srcaddr  = $random(seed);
      p.data     = $random(seed);
      if (kind == 1)
         p.dstaddr[erx_pkg::PAGE_LSB +: erx_pkg::PAGE_W] = erx_pkg::RESP_PAGE;
      else if (kind == 2 && p.dstaddr[erx_pkg::PAGE_LSB +: erx_pkg::PAGE_W] == erx_pkg::RESP_PAGE)
         p.dstaddr[erx_pkg::PAGE_LSB] = ~p.dstaddr[erx_pkg::PAGE_LSB];
      return p;
   endfunction

   // Write with a fixed table index, the table entry picks its queue
   function automatic erx_pkg::erx_packet_t indexed_write(input erx_pkg::erx_mmu_idx_t idx);
      erx_pkg::erx_packet_t p;
      p = random_packet(2);
      p.dstaddr[erx_pkg::MMU_IDX_LSB +: erx_pkg::MMU_IDX_W] = idx;
      return p;
   endfunction

   // Translate and route the way the link spec says, then queue as expected
   task automatic expect_packet(input erx_pkg::erx_packet_t p);
      erx_pkg::erx_packet_t x;
      x = p;
      if (mmu_en)
         x.dstaddr[erx_pkg::PAGE_LSB +: erx_pkg::PAGE_W] =
            page_model[p.dstaddr[erx_pkg::MMU_IDX_LSB +: erx_pkg::MMU_IDX_W]];
      if (!x.write)
         rq_exp.push_back(x);
      else if (x.dstaddr[erx_pkg::PAGE_LSB +: erx_pkg::PAGE_W] == erx_pkg::RESP_PAGE)
         rr_exp.push_back(x);
      else
         wr_exp.push_back(x);
   endtask

   task automatic send_packet(input erx_pkg::erx_packet_t p, input int gap);
      erx_pkg::erx_beat_t hdr;
      erx_pkg::erx_beat_t body;
      while (p.write ? rx_wr_wait : rx_rd_wait)   // No new frame while held off
      begin
         link_idle();
         next_cycle();
      end
      hdr = {$random(seed), $random(seed)};      // Reserved and ignored bytes random
      hdr[erx_pkg::HDR_WRITE_BIT] = p.write;
      hdr[erx_pkg::HDR_DATAMODE_LSB +: erx_pkg::DATAMODE_W] = p.datamode;
      hdr[erx_pkg::HDR_CTRLMODE_LSB +: erx_pkg::CTRLMODE_W] = p.ctrlmode;
      hdr[erx_pkg::HDR_DSTADDR_LSB +: erx_pkg::ADDR_W]      = p.dstaddr;
      body = {p.data, p.srcaddr};
      rx_frame_par = '1;
      rx_data_par  = hdr;
      next_cycle();
      rx_data_par  = body;
      if (rx_enable)
         expect_packet(p);
      next_cycle();                            // Frame bits stay high if gap is 0
      repeat (gap)
      begin
         link_idle();
         next_cycle();
      end
   endtask

   task automatic write_entry(input erx_pkg::erx_mmu_idx_t idx, input erx_pkg::erx_page_t pg);
      mi_en  = 1'b1;
      mi_we  = 1'b1;
      mi_addr = idx;
      mi_din = pg;
      page_model[idx] = pg;
      next_cycle();
      mi_en  = 1'b0;
   endtask

   task automatic read_entry(input erx_pkg::erx_mmu_idx_t idx);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = idx;
      next_cycle();
      mi_en   = 1'b0;
   endtask

   task automatic drain_queues();
      link_idle();
      while (wr_exp.size() + rq_exp.size() + rr_exp.size() != 0)
         next_cycle();
      repeat (6) next_cycle();                 // Room for stray packets to show
   endtask

   task automatic check_front(input string q_name, input int depth,
                              input erx_pkg::erx_packet_t exp_pkt,
                              input erx_pkg::erx_packet_t act_pkt);
      assert (depth > 0)
      else fail_run({q_name, " queue delivered a packet that was never sent"});
      if (depth > 0)
      begin
         assert (act_pkt == exp_pkt)
         else report_mismatch({q_name, " packet"}, $sformatf("%h", exp_pkt),
                              $sformatf("%h", act_pkt));
      end
   endtask

   function automatic logic ready_level(input logic [1:0] mode, input logic flip);
      return (mode == READY_ON) || (mode == READY_RAND && flip);
   endfunction

   always @(posedge rx_lclk_div4)
   begin
      #1;
      coin = $random(seed);
      wr_ready = ready_level(wr_mode, coin[0]);
      rq_ready = ready_level(rq_mode, coin[1]);
      rr_ready = ready_level(rr_mode, coin[2]);
   end

   // Consumers, one handshake per edge and queue
   always @(posedge rx_lclk_div4)
   begin
      if (rst_n && wr_valid && wr_ready)
      begin
         check_front("write", wr_exp.size(), wr_exp[0], wr_pkt);
         wr_exp.delete(0);
      end
      if (rst_n && rq_valid && rq_ready)
      begin
         check_front("request", rq_exp.size(), rq_exp[0], rq_pkt);
         rq_exp.delete(0);
      end
      if (rst_n && rr_valid && rr_ready)
      begin
         check_front("response", rr_exp.size(), rr_exp[0], rr_pkt);
         rr_exp.delete(0);
      end
   end

   always @(posedge rx_lclk_div4)
   begin
      if (!rst_q)                              // During reset and one edge after
      begin
         assert (!wr_valid && !rq_valid && !rr_valid && !rx_wr_wait && !rx_rd_wait)
         else fail_run("a queue valid or link wait was high around reset");
      end
      if (quiet_chk)
      begin
         assert (!wr_valid && !rq_valid && !rr_valid &&
                 wr_exp.size() + rq_exp.size() + rr_exp.size() == 0)
         else fail_run("traffic appeared while the receiver was disabled");
      end
      if (rd_pend)
      begin
         assert (mi_dout == page_model[rd_idx])
         else report_mismatch("page table read", $sformatf("%h", page_model[rd_idx]),
                              $sformatf("%h", mi_dout));
      end
      rst_q   <= rst_n;
      rd_pend <= rst_n && mi_en && !mi_we;
      rd_idx  <= mi_addr;
      cycles  <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         fail_run("timeout, the run did not finish within the cycle limit");
   end

   initial
   begin
      seed = 32'h97fb5784;
      test_name = "reset";
      rx_lclk_div4 = 1'b0;
      rst_n = 1'b0;
      rx_enable = 1'b0;
      mmu_en = 1'b0;
      rx_frame_par = '0;
      rx_data_par = '0;
      mi_en = 1'b0;
      mi_we = 1'b0;
      mi_addr = '0;
      mi_din = '0;
      {wr_ready, rq_ready, rr_ready} = 3'b111;
      {wr_mode, rq_mode, rr_mode} = {READY_ON, READY_ON, READY_ON};
      rst_q = 1'b1;
      rd_pend = 1'b0;
      rd_idx = '0;
      quiet_chk = 1'b0;
      cycles = 0;
      for (i = 0; i < erx_pkg::MMU_ENTRIES; i++)
         page_model[i] = '0;
      repeat (5) @(posedge rx_lclk_div4);
      #1;
      rst_n = 1'b1;
      rx_enable = 1'b1;
      next_cycle();

      test_name = "routing";
      for (i = 0; i < ROUTE_PKTS; i++)
         send_packet(random_packet(i % 3), 0);   // Back-to-back
      {wr_mode, rq_mode, rr_mode} = {READY_RAND, READY_RAND, READY_RAND};
      for (i = 0; i < ROUTE_PKTS; i++)
         send_packet(random_packet(i % 3), i % 4);
      drain_queues();
      {wr_mode, rq_mode, rr_mode} = {READY_ON, READY_ON, READY_ON};

      test_name = "page table";
      for (i = 0; i < erx_pkg::MMU_ENTRIES; i++)
         write_entry(erx_pkg::erx_mmu_idx_t'(i), erx_pkg::erx_page_t'($random(seed)));
      write_entry(4'h3, erx_pkg::RESP_PAGE);   // Two indexes land on responses
      write_entry(4'h5, erx_pkg::RESP_PAGE);
      for (i = 0; i < erx_pkg::MMU_ENTRIES; i++)
         read_entry(erx_pkg::erx_mmu_idx_t'(i));
      repeat (2) next_cycle();

      test_name = "translation";
      mmu_en = 1'b1;
      for (i = 0; i < XLAT_PKTS; i++)
      begin
         if (i % 4 == 0)
            send_packet(indexed_write((i % 8 == 0) ? 4'h3 : 4'h5), i % 2);
         else
            send_packet(random_packet(i % 3), i % 2);
      end
      drain_queues();
      mmu_en = 1'b0;

      test_name = "write back-pressure";
      wr_mode = READY_OFF;
      fork
         begin
            for (i = 0; i < PRESS_PKTS; i++)
               send_packet(random_packet(2), 0);
            link_idle();
         end
         begin
            while (!rx_wr_wait)
               next_cycle();
            wr_mode = READY_RAND;              // Release with random gaps
         end
      join
      drain_queues();
      assert (!rx_wr_wait)
      else fail_run("rx_wr_wait stayed high after the write queue drained");
      wr_mode = READY_ON;

      test_name = "read back-pressure";
      rq_mode = READY_OFF;
      fork
         begin
            for (i = 0; i < PRESS_PKTS; i++)
               send_packet(random_packet(0), 0);
            link_idle();
         end
         begin
            while (!rx_rd_wait)
               next_cycle();
            rq_mode = READY_RAND;
         end
      join
      drain_queues();
      assert (!rx_rd_wait)
      else fail_run("rx_rd_wait stayed high after the request queue drained");
      rq_mode = READY_ON;

      test_name = "receiver disabled";
      rx_enable = 1'b0;
      quiet_chk = 1'b1;
      for (i = 0; i < QUIET_PKTS; i++)
         send_packet(random_packet(i % 3), i % 2);
      link_idle();
      repeat (8) next_cycle();                 // Longer than the path latency
      quiet_chk = 1'b0;
      rx_enable = 1'b1;
      for (i = 0; i < QUIET_PKTS; i++)
         send_packet(random_packet(i % 3), 0);
      drain_queues();

      test_name = "end of run";
      if (wr_exp.size() + rq_exp.size() + rr_exp.size() == 0)
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
      else
      begin
         fail_run("packets were left in the scoreboards");
      end
   end

endmodule

`default_nettype wire

// ==== src.f ====
design/erx_pkg.sv
design/erx_protocol.sv
design/erx_mmu.sv
design/erx_disty.sv
design/erx_queue.sv
design/erx_core.sv
sim/erx_tb.sv

// ==== Bender.yml ====
package:
  name: erx_core

dependencies: {}

sources:
  - design/erx_pkg.sv
  - design/erx_protocol.sv
  - design/erx_mmu.sv
  - design/erx_disty.sv
  - design/erx_queue.sv
  - design/erx_core.sv
  - target: simulation
    files:
      - sim/erx_tb.sv
